// File: logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

    //////////////////////////////////////////////////
    // Geometry
    //////////////////////////////////////////////////

    localparam int ADDR_W        = 32;
    localparam int WORD_W        = 32;
    localparam int TAG_W         = 20;
    localparam int INDEX_W       = 8;
    localparam int WORD_SEL_W    = 2;
    // Byte bits below the word select, ignored
    localparam int BYTE_SEL_W    = ADDR_W - TAG_W - INDEX_W - WORD_SEL_W;
    localparam int LINE_OFFSET_W = WORD_SEL_W + BYTE_SEL_W;
    localparam int LINE_W        = WORD_W * (2 ** WORD_SEL_W);
    localparam int LINE_DEPTH    = 2 ** INDEX_W;
    // Valid bit on top of the tag
    localparam int TAGV_W        = TAG_W + 1;
    localparam int LINE_ADDR_W   = TAG_W + INDEX_W;

    //////////////////////////////////////////////////
    // Address views
    //////////////////////////////////////////////////

    // Lookup view
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [WORD_SEL_W-1:0] word_sel;
        logic [BYTE_SEL_W-1:0] byte_sel;
    } cache_addr_f_t;

    // Memory port view
    typedef struct packed {
        logic [LINE_ADDR_W-1:0]   line_addr;
        logic [LINE_OFFSET_W-1:0] offset;
    } cache_addr_l_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        cache_addr_f_t     f;
        cache_addr_l_t     l;
    } cache_addr_u;

    //////////////////////////////////////////////////
    // Payloads between blocks
    //////////////////////////////////////////////////

    typedef struct packed {
        logic              write;
        cache_addr_u       addr;
        logic [WORD_W-1:0] wdata;
    } cache_req_t;

    typedef struct packed {
        logic                  write;
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [WORD_SEL_W-1:0] word_sel;
        logic [WORD_W-1:0]     wdata;
    } lookup_ctl_t;

    typedef struct packed {
        logic                   write;
        logic [LINE_ADDR_W-1:0] line_addr;
        logic [WORD_SEL_W-1:0]  word_sel;
        logic [WORD_W-1:0]      wdata;
    } mem_req_t;

    typedef struct packed {
        logic                  write;
        logic                  hit;
        logic [WORD_SEL_W-1:0] word_sel;
        logic [LINE_W-1:0]     line;
    } resp_info_t;

    typedef struct packed {
        logic [WORD_W-1:0] rdata;
        logic              hit;
        logic              write;
    } cache_resp_t;

endpackage

`default_nettype wire

// File: logic/line_ram.sv
`timescale 1ns/1ps
`default_nettype none

module line_ram #(
    parameter int RAM_WIDTH = 128,
    parameter int RAM_DEPTH = 256
) (
    input  logic                         clka,
    input  logic                         we,
    input  logic [$clog2(RAM_DEPTH)-1:0] wr_index,
    input  logic [$clog2(RAM_DEPTH)-1:0] rd_index,
    input  logic [RAM_WIDTH-1:0]         din,
    output logic [RAM_WIDTH-1:0]         dout
);

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    logic [RAM_WIDTH-1:0]         mem [RAM_DEPTH];
    // Read address, captured every edge
    logic [$clog2(RAM_DEPTH)-1:0] rd_index_q;

    // Power-up contents all zero, so every valid bit starts clear
    initial begin
        for (int i = 0; i < RAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Write port
    always_ff @(posedge clka) begin
        if (we) begin
            mem[wr_index] <= din;
        end
    end

    // Registered read address
    always_ff @(posedge clka) begin
        rd_index_q <= rd_index;
    end

    // Array read after the address register
    // a write to the same entry shows up right after its edge
    assign dout = mem[rd_index_q];

endmodule

`default_nettype wire

// File: logic/cache_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cache_req_decode
    import cache_pkg::*;
(
    input  logic               clka,
    input  logic               arst_n,
    input  logic               req_valid,
    input  cache_req_t         req,
    input  logic               rsp_done,
    output logic               ctl_valid,
    output lookup_ctl_t        ctl,
    output logic [INDEX_W-1:0] rd_index
);

    // Request accepted, response not yet seen
    logic inflight_q;

    //////////////////////////////////////////////////
    // Strobe and in-flight tracking
    //////////////////////////////////////////////////

    always_ff @(posedge clka or negedge arst_n) begin
        if (!arst_n) begin
            ctl_valid  <= 1'b0;
            inflight_q <= 1'b0;
        end else begin
            ctl_valid <= req_valid;
            // New strobe wins over a response in the same cycle
            if (req_valid) begin
                inflight_q <= 1'b1;
            end else if (rsp_done) begin
                inflight_q <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Address split
    //////////////////////////////////////////////////

    // Held until the next strobe, lookup reads it for the whole miss
    always_ff @(posedge clka) begin
        if (req_valid) begin
            ctl.write    <= req.write;
            ctl.tag      <= req.addr.f.tag;
            ctl.index    <= req.addr.f.index;
            ctl.word_sel <= req.addr.f.word_sel;
            ctl.wdata    <= req.wdata;
        end
    end

    // Index goes to both RAMs, captured there on the next edge
    assign rd_index = ctl.index;

    // No strobe while busy, except in the response cycle itself
    a_no_req_in_flight: assert property (
        @(posedge clka) disable iff (!arst_n)
        req_valid |-> (!inflight_q || rsp_done)
    ) else $error("request strobed while a request is in flight");

endmodule

`default_nettype wire

// File: logic/cache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module cache_lookup
    import cache_pkg::*;
(
    input  logic               clka,
    input  logic               arst_n,
    input  logic               ctl_valid,
    input  lookup_ctl_t        ctl,
    input  logic [TAGV_W-1:0]  tagv_q,
    input  logic [LINE_W-1:0]  line_q,
    input  logic               mem_rsp_valid,
    input  logic [LINE_W-1:0]  mem_rsp_line,
    output logic               tagv_we,
    output logic               data_we,
    output logic [INDEX_W-1:0] wr_index,
    output logic [TAGV_W-1:0]  tagv_d,
    output logic [LINE_W-1:0]  line_d,
    output logic               mem_req_valid,
    output mem_req_t           mem_req,
    output logic               info_valid,
    output resp_info_t         resp_info,
    output logic               busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_REFILL
    } state_t;

    state_t            state_q;
    state_t            state_d;
    cache_addr_u       cur_addr;
    logic              tag_valid;
    logic              hit;
    logic [LINE_W-1:0] line_merged;

    //////////////////////////////////////////////////
    // Tag compare and write merge
    //////////////////////////////////////////////////

    // RAM outputs are valid only in compare
    assign tag_valid = tagv_q[TAGV_W-1];
    assign hit       = tag_valid && (tagv_q[TAG_W-1:0] == ctl.tag);

    // Replace one word of the cached line
    always_comb begin
        line_merged = line_q;
        line_merged[ctl.word_sel*WORD_W +: WORD_W] = ctl.wdata;
    end

    // Rebuild the byte address to read it back as a line address
    always_comb begin
        cur_addr.f.tag      = ctl.tag;
        cur_addr.f.index    = ctl.index;
        cur_addr.f.word_sel = ctl.word_sel;
        cur_addr.f.byte_sel = '0;
    end

    //////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clka or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (ctl_valid) begin
                    state_d = ST_COMPARE;
                end
            end
            ST_COMPARE: begin
                // Only a read miss waits for memory
                if (!ctl.write && !hit) begin
                    state_d = ST_REFILL;
                end else begin
                    state_d = ST_IDLE;
                end
            end
            ST_REFILL: begin
                if (mem_rsp_valid) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // Busy from the decode strobe until the response is registered
    assign busy = ctl_valid || (state_q != ST_IDLE);

    //////////////////////////////////////////////////
    // RAM write ports
    //////////////////////////////////////////////////

    // Write hit touches data only
    // Refill writes both RAMs
    assign data_we  = ((state_q == ST_COMPARE) && ctl.write && hit)
                   || ((state_q == ST_REFILL) && mem_rsp_valid);
    assign tagv_we  = (state_q == ST_REFILL) && mem_rsp_valid;
    assign wr_index = ctl.index;
    assign tagv_d   = {1'b1, ctl.tag};
    assign line_d   = (state_q == ST_REFILL) ? mem_rsp_line : line_merged;

    //////////////////////////////////////////////////
    // Memory port
    //////////////////////////////////////////////////

    // Every write goes out to memory but a read only on a miss
    assign mem_req_valid     = (state_q == ST_COMPARE) && (ctl.write || !hit);
    assign mem_req.write     = ctl.write;
    assign mem_req.line_addr = cur_addr.l.line_addr;
    assign mem_req.word_sel  = ctl.word_sel;
    assign mem_req.wdata     = ctl.wdata;

    //////////////////////////////////////////////////
    // Hand-off to response
    //////////////////////////////////////////////////

    assign info_valid = ((state_q == ST_COMPARE) && (ctl.write || hit))
                     || ((state_q == ST_REFILL) && mem_rsp_valid);

    always_comb begin
        resp_info.word_sel = ctl.word_sel;
        if (state_q == ST_REFILL) begin
            resp_info.write = 1'b0;
            resp_info.hit   = 1'b0;
            resp_info.line  = mem_rsp_line;
        end else begin
            resp_info.write = ctl.write;
            resp_info.hit   = hit;
            resp_info.line  = line_q;
        end
    end

    // Memory must not answer what was never asked
    a_rsp_only_in_refill: assert property (
        @(posedge clka) disable iff (!arst_n)
        mem_rsp_valid |-> (state_q == ST_REFILL)
    ) else $error("memory response outside refill wait");

    // A RAM write is the last step of a request
    a_write_ends_request: assert property (
        @(posedge clka) disable iff (!arst_n)
        (tagv_we || data_we) |=> (state_q == ST_IDLE)
    ) else $error("RAM write not followed by idle");

endmodule

`default_nettype wire

// File: logic/cache_resp.sv
`timescale 1ns/1ps
`default_nettype none

module cache_resp
    import cache_pkg::*;
(
    input  logic        clka,
    input  logic        arst_n,
    input  logic        info_valid,
    input  resp_info_t  resp_info,
    output logic        rsp_valid,
    output cache_resp_t rsp
);

    // Word picked out of the forwarded line
    logic [WORD_W-1:0] word_sel_data;

    //////////////////////////////////////////////////
    // Word select
    //////////////////////////////////////////////////

    assign word_sel_data = resp_info.line[resp_info.word_sel*WORD_W +: WORD_W];

    //////////////////////////////////////////////////
    // Response register
    //////////////////////////////////////////////////

    always_ff @(posedge clka or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= info_valid;
        end
    end

    always_ff @(posedge clka) begin
        if (info_valid) begin
            // Writes return no data
            rsp.rdata <= resp_info.write ? '0 : word_sel_data;
            rsp.hit   <= resp_info.hit;
            rsp.write <= resp_info.write;
        end
    end

    // One request in flight, so never two responses back to back
    a_rsp_single_cycle: assert property (
        @(posedge clka) disable iff (!arst_n)
        rsp_valid |=> !rsp_valid
    ) else $error("rsp_valid high for two cycles");

endmodule

`default_nettype wire

// File: logic/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import cache_pkg::*;
(
    input  logic              clka,
    input  logic              arst_n,
    // Requester side
    input  logic              req_valid,
    input  cache_req_t        req,
    output logic              busy,
    output logic              rsp_valid,
    output cache_resp_t       rsp,
    // Memory side
    output logic              mem_req_valid,
    output mem_req_t          mem_req,
    input  logic              mem_rsp_valid,
    input  logic [LINE_W-1:0] mem_rsp_line
);

    logic               ctl_valid;
    lookup_ctl_t        ctl;
    logic [INDEX_W-1:0] rd_index;
    logic [INDEX_W-1:0] wr_index;
    logic               tagv_we;
    logic               data_we;
    logic [TAGV_W-1:0]  tagv_d;
    logic [TAGV_W-1:0]  tagv_q;
    logic [LINE_W-1:0]  line_d;
    logic [LINE_W-1:0]  line_q;
    logic               info_valid;
    resp_info_t         resp_info;

    //////////////////////////////////////////////////
    // Request capture
    //////////////////////////////////////////////////

    // Response strobe closes the in-flight window
    cache_req_decode cache_req_decode_inst (
        .clka      (clka),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_done  (rsp_valid),
        .ctl_valid (ctl_valid),
        .ctl       (ctl),
        .rd_index  (rd_index)
    );

    //////////////////////////////////////////////////
    // Line and tag storage
    //////////////////////////////////////////////////

    line_ram #(
        .RAM_WIDTH (LINE_W),
        .RAM_DEPTH (LINE_DEPTH)
    ) data_ram (
        .clka     (clka),
        .we       (data_we),
        .wr_index (wr_index),
        .rd_index (rd_index),
        .din      (line_d),
        .dout     (line_q)
    );

    line_ram #(
        .RAM_WIDTH (TAGV_W),
        .RAM_DEPTH (LINE_DEPTH)
    ) tagv_ram (
        .clka     (clka),
        .we       (tagv_we),
        .wr_index (wr_index),
        .rd_index (rd_index),
        .din      (tagv_d),
        .dout     (tagv_q)
    );

    //////////////////////////////////////////////////
    // Compare, refill and response
    //////////////////////////////////////////////////

    cache_lookup cache_lookup_inst (
        .clka          (clka),
        .arst_n        (arst_n),
        .ctl_valid     (ctl_valid),
        .ctl           (ctl),
        .tagv_q        (tagv_q),
        .line_q        (line_q),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_line  (mem_rsp_line),
        .tagv_we       (tagv_we),
        .data_we       (data_we),
        .wr_index      (wr_index),
        .tagv_d        (tagv_d),
        .line_d        (line_d),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .info_valid    (info_valid),
        .resp_info     (resp_info),
        .busy          (busy)
    );

    cache_resp cache_resp_inst (
        .clka       (clka),
        .arst_n     (arst_n),
        .info_valid (info_valid),
        .resp_info  (resp_info),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

endmodule

`default_nettype wire

// File: verif/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
    import cache_pkg::*;
();

    localparam int NUM_REQS = 400;
    localparam int TIMEOUT  = 100;
    localparam int SEED     = 80;

    logic              clka;
    logic              arst_n;
    logic              req_valid;
    cache_req_t        req;
    logic              busy;
    logic              rsp_valid;
    cache_resp_t       rsp;
    logic              mem_req_valid;
    mem_req_t          mem_req;
    logic              mem_rsp_valid;
    logic [LINE_W-1:0] mem_rsp_line;

    // Backing memory holds only written words
    logic [WORD_W-1:0]  mem_words [logic [ADDR_W-3:0]];
    // Cache model with one valid bit and tag per index
    logic               cache_valid [LINE_DEPTH];
    logic [TAG_W-1:0]   cache_tag [LINE_DEPTH];

    // Request being served and the one after it
    logic               cur_wr;
    cache_addr_u        cur_addr;
    logic [WORD_W-1:0]  cur_wdata;
    logic               nxt_wr;
    cache_addr_u        nxt_addr;
    logic [WORD_W-1:0]  nxt_wdata;
    // Next request goes out in the response cycle
    logic               overlap_next;
    logic               launched;

    dcache_top dcache_top_inst (
        .clka          (clka),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req           (req),
        .busy          (busy),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_line  (mem_rsp_line)
    );

    // 4 ns period
    always #2 clka = ~clka;

    //////////////////////////////////////////////////
    // Failure reporting and checks
    //////////////////////////////////////////////////

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("** Error: %s is 0x%0h, expected 0x%0h",
                                        name, actual, expected));
        end
    endtask

    //////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////

    // Power-up word mixes every address bit
    function automatic logic [WORD_W-1:0] fill_word(input logic [ADDR_W-3:0] waddr);
        return (waddr * 32'h9E37_79B1) ^ {waddr, 2'b11};
    endfunction

    function automatic logic [WORD_W-1:0] mem_read(input logic [ADDR_W-3:0] waddr);
        if (mem_words.exists(waddr)) begin
            return mem_words[waddr];
        end
        return fill_word(waddr);
    endfunction

    // Word w of the line sits at bits w*32
    function automatic logic [LINE_W-1:0] mem_line(input logic [LINE_ADDR_W-1:0] laddr);
        logic [LINE_W-1:0] line;
        for (int w = 0; w < 4; w++) begin
            line[w*WORD_W +: WORD_W] = mem_read({laddr, 2'(w)});
        end
        return line;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // 4 tags x 4 indices x 4 words with about 60% reads
    task automatic gen_request(output logic wr, output cache_addr_u addr,
                               output logic [WORD_W-1:0] wdata);
        addr.f.tag      = {18'h2D1C4, 2'($urandom_range(0, 3))};
        addr.f.index    = {2'($urandom_range(0, 3)), 6'h2A};
        addr.f.word_sel = 2'($urandom_range(0, 3));
        addr.f.byte_sel = '0;
        wr              = ($urandom_range(0, 99) >= 60);
        wdata           = $urandom;
    endtask

    // Called right after a rising edge
    task automatic drive_request(input logic wr, input cache_addr_u addr,
                                 input logic [WORD_W-1:0] wdata);
        req_valid <= 1'b1;
        req.write <= wr;
        req.addr  <= addr;
        req.wdata <= wdata;
    endtask

    // One request from strobe to response
    // One loop pass per clock
    task automatic serve_request();
        logic              exp_hit;
        logic [WORD_W-1:0] exp_rdata;
        logic [LINE_W-1:0] refill_line;
        logic              got;
        int                iter;
        int                rsp_iter;
        int                mem_reqs;
        int                mem_delay;
        exp_hit   = cache_valid[cur_addr.f.index]
                    && (cache_tag[cur_addr.f.index] == cur_addr.f.tag);
        got       = 1'b0;
        iter      = 0;
        // Hits and writes answer two edges after sampling
        rsp_iter  = 3;
        mem_reqs  = 0;
        mem_delay = 0;
        if (!launched) begin
            @(posedge clka);
            drive_request(cur_wr, cur_addr, cur_wdata);
        end
        launched = 1'b0;
        while (!got) begin
            // First pass edge is the sampling edge
            @(posedge clka);
            iter++;
            if (iter == 1) begin
                req_valid <= 1'b0;
            end
            // Refill countdown then the line strobed for one cycle
            if (mem_delay > 0) begin
                mem_delay--;
                if (mem_delay == 0) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_line  <= refill_line;
                end
            end else begin
                mem_rsp_valid <= 1'b0;
            end
            if ((iter == rsp_iter) && overlap_next) begin
                drive_request(nxt_wr, nxt_addr, nxt_wdata);
                launched = 1'b1;
            end
            @(negedge clka);
            if (iter > TIMEOUT) begin
                if (!cur_wr && !exp_hit && (mem_reqs == 0)) begin
                    stop_with_failure("Error: mem_req_valid for a refill never came");
                end else begin
                    stop_with_failure("Error: rsp_valid never came");
                end
            end
            if (mem_req_valid) begin
                mem_reqs++;
                check_value("mem_req.write", mem_req.write, cur_wr);
                check_value("mem_req.line_addr", mem_req.line_addr, cur_addr.raw[31:4]);
                if (cur_wr) begin
                    check_value("mem_req.word_sel", mem_req.word_sel, cur_addr.raw[3:2]);
                    check_value("mem_req.wdata", mem_req.wdata, cur_wdata);
                    // Write-through lands at once
                    mem_words[cur_addr.raw[31:2]] = cur_wdata;
                end else begin
                    refill_line = mem_line(cur_addr.raw[31:4]);
                    mem_delay   = $urandom_range(1, 8);
                    rsp_iter    = iter + mem_delay + 1;
                end
            end
            if (rsp_valid) begin
                got       = 1'b1;
                exp_rdata = cur_wr ? '0 : mem_read(cur_addr.raw[31:2]);
                check_value("rsp_valid cycle", iter, rsp_iter);
                check_value("busy", busy, 1'b0);
                check_value("rsp.write", rsp.write, cur_wr);
                check_value("rsp.hit", rsp.hit, exp_hit);
                check_value("rsp.rdata", rsp.rdata, exp_rdata);
            end else begin
                check_value("busy", busy, 1'b1);
            end
        end
        check_value("mem_req_valid count", mem_reqs, (cur_wr || !exp_hit) ? 1 : 0);
        // Only a read miss allocates
        if (!cur_wr && !exp_hit) begin
            cache_valid[cur_addr.f.index] = 1'b1;
            cache_tag[cur_addr.f.index]   = cur_addr.f.tag;
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        clka          = 1'b0;
        arst_n        = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        mem_rsp_valid = 1'b0;
        mem_rsp_line  = '0;
        launched      = 1'b0;
        overlap_next  = 1'b0;
        for (int i = 0; i < LINE_DEPTH; i++) begin
            cache_valid[i] = 1'b0;
            cache_tag[i]   = '0;
        end
        repeat (2) @(posedge clka);
        arst_n <= 1'b1;
        // Quiet until the first request
        repeat (4) begin
            @(negedge clka);
            check_value("busy", busy, 1'b0);
            check_value("rsp_valid", rsp_valid, 1'b0);
            check_value("mem_req_valid", mem_req_valid, 1'b0);
        end
        gen_request(nxt_wr, nxt_addr, nxt_wdata);
        for (int n = 0; n < NUM_REQS; n++) begin
            cur_wr       = nxt_wr;
            cur_addr     = nxt_addr;
            cur_wdata    = nxt_wdata;
            overlap_next = 1'b0;
            if (n < NUM_REQS - 1) begin
                gen_request(nxt_wr, nxt_addr, nxt_wdata);
                overlap_next = ($urandom_range(0, 1) == 1);
            end
            serve_request();
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
logic/cache_pkg.sv
logic/line_ram.sv
logic/cache_req_decode.sv
logic/cache_lookup.sv
logic/cache_resp.sv
logic/dcache_top.sv
verif/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  # Design, package first
  - files:
      - logic/cache_pkg.sv
      - logic/line_ram.sv
      - logic/cache_req_decode.sv
      - logic/cache_lookup.sv
      - logic/cache_resp.sv
      - logic/dcache_top.sv

  # Testbench
  - target: simulation
    files:
      - verif/dcache_tb.sv
